// ==== sha_accel_params.svh ====
`ifndef SHA_ACCEL_PARAMS_SVH
`define SHA_ACCEL_PARAMS_SVH

// ----------------------------------------------------------------------
// widths and depths

`define SHA_WORD_W        32                // bus data, fifo entry, hash word
`define SHA_BUS_AW        20                // decoded part of the bus address
`define SHA_HASH_W        256               // full digest, H0 on top
`define SHA_FIFO_AW       8                 // fifo depth is 2**AW

// ----------------------------------------------------------------------
// register map, byte addresses

`define REG_CTRL          20'h00000         // global control
`define REG_STATUS        20'h00004         // global status, read only
`define REG_VERSION       20'h0000C         // version word, read only
`define REG_SHA_CTRL      20'h00100         // engine control
`define REG_SHA_STATUS    20'h00104         // engine status, read only
`define REG_SHA_PUSH      20'h0010C         // fifo push port, write only
`define REG_SHA_HASH_BASE 20'h00110         // H7 here, H0 at +0x1C
`define REG_SHA_FIFO_CNT  20'h00130         // fifo fill count

// control bit positions
`define CTRL_ENABLE       0
`define SHA_CTRL_ENABLE   0
`define SHA_CTRL_RESET    1                 // one-shot, clears itself

`define BUILD_DATE        32'h0001_0003     // version word

`endif

// ==== sha_accel_pkg.sv ====
`default_nettype none

`include "sha_accel_params.svh"

package sha_accel_pkg;

  // ----------------------------------------------------------------------
  // plain vectors with a meaning

  typedef logic [`SHA_WORD_W-1:0]  word_t;      // one 32 bit data word
  typedef logic [`SHA_BUS_AW-1:0]  bus_addr_t;  // decoded bus address
  typedef logic [`SHA_HASH_W-1:0]  hash_t;      // H0 in the msb word
  typedef logic [`SHA_FIFO_AW:0]   fifo_cnt_t;  // 0 .. full depth

  // compressor sequencing
  typedef enum logic [1:0] {
    IDLE,   // one cycle after reset
    LOAD,   // taking 16 words
    ROUND,  // 64 rounds, one per cycle
    FINAL   // fold into chaining state
  } comp_state_e;

endpackage

`default_nettype wire

// ==== sha_bus_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sha_accel_params.svh"

module sha_bus_regs (
  input  wire                           bus_clk,
  input  wire                           bus_rstn,
  input  wire sha_accel_pkg::bus_addr_t sys_addr_i,
  input  wire sha_accel_pkg::word_t     sys_wdata_i,
  input  wire                           sys_wen_i,
  input  wire                           sys_ren_i,
  input  wire                           full_i,        // fifo cannot take a word
  input  wire sha_accel_pkg::fifo_cnt_t count_i,       // fifo fill level
  input  wire sha_accel_pkg::hash_t     hash_i,        // chaining state of the engine
  input  wire                           hash_valid_i,
  input  wire                           busy_i,
  output sha_accel_pkg::word_t          sys_rdata_o,
  output logic                          sys_ack_o,
  output logic                          sys_err_o,
  output logic                          push_valid_o,  // one cycle per accepted push
  output sha_accel_pkg::word_t          push_data_o,
  output logic                          sha_rstn_o,    // engine soft reset, active low
  output logic                          x11_activated_o
);
  import sha_accel_pkg::*;

  // last free slot, as seen from the count
  localparam fifo_cnt_t LAST_SLOT = fifo_cnt_t'((1 << `SHA_FIFO_AW) - 1);

  word_t     ctrl_q;         // global control
  word_t     sha_ctrl_q;     // engine control, reset bit is a one-shot
  hash_t     hash_q;         // captured digest
  logic      hash_valid_d;   // edge detect on hash valid
  logic      global_en;
  logic      sha_en;
  logic      sha_rst_shot;
  logic      push_blocked;   // a push now would overrun the fifo
  word_t     status_w;
  word_t     sha_status_w;
  bus_addr_t hash_off;       // offset into the hash window
  logic      hash_hit;

  // ----------------------------------------------------------------------
  // control decode and soft reset

  assign global_en       = ctrl_q[`CTRL_ENABLE];
  assign sha_en          = sha_ctrl_q[`SHA_CTRL_ENABLE];
  assign sha_rst_shot    = sha_ctrl_q[`SHA_CTRL_RESET];
  assign x11_activated_o = global_en;

  // any of the four pulls the engine into reset
  assign sha_rstn_o = bus_rstn & global_en & sha_en & ~sha_rst_shot;

  // count lags the push by one cycle, so a push still in flight counts too
  assign push_blocked = full_i | (push_valid_o & (count_i == LAST_SLOT));

  assign status_w     = {27'b0, sha_rstn_o, 3'b0, global_en};
  assign sha_status_w = {25'b0, full_i, 1'b0, (count_i == '0), 2'b0, hash_valid_i, ~busy_i};

  // H7 sits at the base and maps to the lsb word of the digest
  assign hash_off = sys_addr_i - `REG_SHA_HASH_BASE;
  assign hash_hit = (hash_off < 20'd32);

  // ----------------------------------------------------------------------
  // write side

  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      ctrl_q       <= '0;
      sha_ctrl_q   <= '0;
      push_valid_o <= 1'b0;
    end else begin
      sha_ctrl_q[`SHA_CTRL_RESET] <= 1'b0;     // one-shot drops after a cycle
      push_valid_o                <= 1'b0;
      if (sys_wen_i) begin
        case (sys_addr_i)
          `REG_CTRL:     ctrl_q       <= sys_wdata_i;
          `REG_SHA_CTRL: sha_ctrl_q   <= sys_wdata_i;
          `REG_SHA_PUSH: push_valid_o <= ~push_blocked;  // dropped when full
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (sys_wen_i && (sys_addr_i == `REG_SHA_PUSH)) begin
      push_data_o <= sys_wdata_i;
    end
  end

  // ----------------------------------------------------------------------
  // response, ack and data one cycle after the request

  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o   <= sys_wen_i | sys_ren_i;
      sys_err_o   <= sys_wen_i & (sys_addr_i == `REG_SHA_PUSH) & push_blocked;
      sys_rdata_o <= '0;                        // unmapped and write-only read 0
      if (sys_ren_i) begin
        case (sys_addr_i)
          `REG_CTRL:         sys_rdata_o <= ctrl_q;
          `REG_STATUS:       sys_rdata_o <= status_w;
          `REG_VERSION:      sys_rdata_o <= `BUILD_DATE;
          `REG_SHA_CTRL: begin
            // one-shot never reads back as set
            sys_rdata_o <= sha_ctrl_q & ~(word_t'(1) << `SHA_CTRL_RESET);
          end
          `REG_SHA_STATUS:   sys_rdata_o <= sha_status_w;
          `REG_SHA_FIFO_CNT: sys_rdata_o <= word_t'(count_i);
          default: begin
            if (hash_hit) begin
              sys_rdata_o <= hash_q[hash_off[4:2]*32 +: 32];
            end
          end
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // hash capture on the rising edge of hash valid

  always_ff @(posedge bus_clk) begin
    if (!sha_rstn_o) begin
      hash_q       <= '0;
      hash_valid_d <= 1'b0;
    end else begin
      hash_valid_d <= hash_valid_i;
      if (hash_valid_i && !hash_valid_d) begin
        hash_q <= hash_i;
      end
    end
  end

  // an ack only repeats when a new request stands behind it
  a_ack_single: assert property (@(posedge bus_clk) disable iff (!bus_rstn)
    sys_ack_o && !(sys_wen_i || sys_ren_i) |=> !sys_ack_o);

  // the fifo is never offered a word it has no room for
  a_push_not_full: assert property (@(posedge bus_clk) disable iff (!bus_rstn)
    push_valid_o |-> !full_i);

endmodule

`default_nettype wire

// ==== sha_word_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sha_accel_params.svh"

module sha_word_fifo #(
  parameter int AW = `SHA_FIFO_AW             // depth is 2**AW
) (
  input  wire                       bus_clk,
  input  wire                       sha_rstn_i,
  input  wire                       push_valid_i,
  input  wire sha_accel_pkg::word_t push_data_i,
  input  wire                       word_ready_i,   // compressor takes the head
  output logic                      full_o,
  output sha_accel_pkg::fifo_cnt_t  count_o,
  output logic                      word_valid_o,
  output sha_accel_pkg::word_t      word_data_o
);
  import sha_accel_pkg::*;

  localparam int DEPTH = 1 << AW;

  word_t         mem_q [DEPTH];   // storage, no reset
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   cnt_q;           // occupancy 0 .. DEPTH
  logic          wr_en;
  logic          rd_en;

  assign full_o       = cnt_q[AW];              // msb only set at DEPTH
  assign word_valid_o = (cnt_q != '0);
  assign word_data_o  = mem_q[rd_ptr_q];        // head shown directly
  assign count_o      = fifo_cnt_t'(cnt_q);

  assign wr_en = push_valid_i & ~full_o;
  assign rd_en = word_valid_o & word_ready_i;

  always_ff @(posedge bus_clk) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // pointers wrap on their own at the power of two depth
  always_ff @(posedge bus_clk) begin
    if (!sha_rstn_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ;                              // none, or one in one out
      endcase
    end
  end

  // the bus side holds pushes back once the count says full
  a_no_write_full: assert property (@(posedge bus_clk) disable iff (!sha_rstn_i)
    full_o |-> !push_valid_i);

  // empty leaves the read pointer on the write pointer, never past it
  a_no_read_empty: assert property (@(posedge bus_clk) disable iff (!sha_rstn_i)
    !word_valid_o |-> (rd_ptr_q == wr_ptr_q));

endmodule

`default_nettype wire

// ==== sha256_compress.sv ====
`timescale 1ns/1ps
`default_nettype none

module sha256_compress (
  input  wire                       bus_clk,
  input  wire                       sha_rstn_i,
  input  wire                       word_valid_i,
  input  wire sha_accel_pkg::word_t word_data_i,   // pre-padded message word
  output logic                      word_ready_o,
  output sha_accel_pkg::hash_t      hash_o,        // chaining state, H0 on top
  output logic                      hash_valid_o,
  output logic                      busy_o
);
  import sha_accel_pkg::*;

  // ----------------------------------------------------------------------
  // round constants and initial hash

  localparam word_t K [64] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  localparam hash_t IV = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  comp_state_e state_q;
  logic [3:0]  load_cnt_q;       // words taken in this block
  logic [5:0]  rnd_q;            // round index
  word_t       w_q [16];         // schedule window, w_q[0] is W[t]
  word_t       v_q [8];          // working vars a .. h
  hash_t       chain_q;
  logic        take;             // word handshake
  word_t       sum1;
  word_t       sum0;
  word_t       ch;
  word_t       maj;
  word_t       t1;
  word_t       t2;
  word_t       w_new;            // W[t+16]

  function automatic word_t rotr(input word_t x, input int unsigned n);
    rotr = (x >> n) | (x << (32 - n));
  endfunction

  assign word_ready_o = (state_q == LOAD);
  assign take         = word_valid_i & word_ready_o;
  assign hash_o       = chain_q;
  assign busy_o       = (state_q == ROUND) | (state_q == FINAL) | (load_cnt_q != '0);

  // ----------------------------------------------------------------------
  // one round and the next schedule word

  always_comb begin
    sum1  = rotr(v_q[4], 6) ^ rotr(v_q[4], 11) ^ rotr(v_q[4], 25);
    ch    = (v_q[4] & v_q[5]) ^ (~v_q[4] & v_q[6]);
    t1    = v_q[7] + sum1 + ch + K[rnd_q] + w_q[0];
    sum0  = rotr(v_q[0], 2) ^ rotr(v_q[0], 13) ^ rotr(v_q[0], 22);
    maj   = (v_q[0] & v_q[1]) ^ (v_q[0] & v_q[2]) ^ (v_q[1] & v_q[2]);
    t2    = sum0 + maj;
    w_new = (rotr(w_q[14], 17) ^ rotr(w_q[14], 19) ^ (w_q[14] >> 10))  // sigma1
          + w_q[9]
          + (rotr(w_q[1], 7) ^ rotr(w_q[1], 18) ^ (w_q[1] >> 3))       // sigma0
          + w_q[0];
  end

  // ----------------------------------------------------------------------
  // sequencing and chaining state

  always_ff @(posedge bus_clk) begin
    if (!sha_rstn_i) begin
      state_q      <= IDLE;
      load_cnt_q   <= '0;
      rnd_q        <= '0;
      chain_q      <= IV;
      hash_valid_o <= 1'b0;
    end else begin
      case (state_q)
        IDLE: state_q <= LOAD;
        LOAD: begin
          if (take) begin
            hash_valid_o <= 1'b0;               // next block has started
            load_cnt_q   <= load_cnt_q + 4'd1;  // wraps to 0 after the 16th
            if (load_cnt_q == 4'd15) begin
              state_q <= ROUND;
            end
          end
        end
        ROUND: begin
          rnd_q <= rnd_q + 6'd1;
          if (rnd_q == 6'd63) begin
            state_q <= FINAL;
          end
        end
        FINAL: begin
          for (int i = 0; i < 8; i++) begin
            chain_q[(7-i)*32 +: 32] <= chain_q[(7-i)*32 +: 32] + v_q[i];
          end
          hash_valid_o <= 1'b1;
          state_q      <= LOAD;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // schedule window and working vars, payload only
  always_ff @(posedge bus_clk) begin
    if (take) begin
      for (int i = 0; i < 15; i++) begin
        w_q[i] <= w_q[i+1];
      end
      w_q[15] <= word_data_i;
      if (load_cnt_q == 4'd15) begin            // start from the chaining state
        for (int i = 0; i < 8; i++) begin
          v_q[i] <= chain_q[(7-i)*32 +: 32];
        end
      end
    end else if (state_q == ROUND) begin
      for (int i = 0; i < 15; i++) begin
        w_q[i] <= w_q[i+1];
      end
      w_q[15] <= w_new;
      v_q[0]  <= t1 + t2;
      v_q[1]  <= v_q[0];
      v_q[2]  <= v_q[1];
      v_q[3]  <= v_q[2];
      v_q[4]  <= v_q[3] + t1;
      v_q[5]  <= v_q[4];
      v_q[6]  <= v_q[5];
      v_q[7]  <= v_q[6];
    end
  end

  // after the 16th word no word is taken for 65 cycles, then the digest is up
  a_block_timing: assert property (@(posedge bus_clk) disable iff (!sha_rstn_i)
    take && (load_cnt_q == 4'd15) |=> !word_ready_o [*65] ##1 (hash_valid_o && word_ready_o));

  // round counter only moves inside ROUND
  a_rnd_range: assert property (@(posedge bus_clk) disable iff (!sha_rstn_i)
    (state_q != ROUND) |-> (rnd_q == '0));

endmodule

`default_nettype wire

// ==== sha_accel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sha_accel_params.svh"

module sha_accel_top (
  input  wire                           bus_clk,
  input  wire                           bus_rstn,
  input  wire sha_accel_pkg::bus_addr_t sys_addr_i,
  input  wire sha_accel_pkg::word_t     sys_wdata_i,
  input  wire                           sys_wen_i,
  input  wire                           sys_ren_i,
  output wire sha_accel_pkg::word_t     sys_rdata_o,
  output wire                           sys_ack_o,
  output wire                           sys_err_o,
  output wire                           x11_activated_o  // global enable
);
  import sha_accel_pkg::*;

  wire            sha_rstn;     // soft reset for fifo, compressor and hash regs
  wire            push_valid;
  wire word_t     push_data;
  wire            fifo_full;
  wire fifo_cnt_t fifo_cnt;
  wire            word_valid;   // fifo to compressor handshake
  wire            word_ready;
  wire word_t     word_data;
  wire hash_t     hash;
  wire            hash_valid;
  wire            busy;

  // ----------------------------------------------------------------------
  // bus registers, fifo, compressor

  sha_bus_regs i_regs (
    .bus_clk         (bus_clk),
    .bus_rstn        (bus_rstn),
    .sys_addr_i      (sys_addr_i),
    .sys_wdata_i     (sys_wdata_i),
    .sys_wen_i       (sys_wen_i),
    .sys_ren_i       (sys_ren_i),
    .full_i          (fifo_full),
    .count_i         (fifo_cnt),
    .hash_i          (hash),
    .hash_valid_i    (hash_valid),
    .busy_i          (busy),
    .sys_rdata_o     (sys_rdata_o),
    .sys_ack_o       (sys_ack_o),
    .sys_err_o       (sys_err_o),
    .push_valid_o    (push_valid),
    .push_data_o     (push_data),
    .sha_rstn_o      (sha_rstn),
    .x11_activated_o (x11_activated_o)
  );

  sha_word_fifo #(
    .AW (`SHA_FIFO_AW)
  ) i_fifo (
    .bus_clk      (bus_clk),
    .sha_rstn_i   (sha_rstn),
    .push_valid_i (push_valid),
    .push_data_i  (push_data),
    .word_ready_i (word_ready),
    .full_o       (fifo_full),
    .count_o      (fifo_cnt),
    .word_valid_o (word_valid),
    .word_data_o  (word_data)
  );

  sha256_compress i_compress (
    .bus_clk      (bus_clk),
    .sha_rstn_i   (sha_rstn),
    .word_valid_i (word_valid),
    .word_data_i  (word_data),
    .word_ready_o (word_ready),
    .hash_o       (hash),
    .hash_valid_o (hash_valid),
    .busy_o       (busy)
  );

endmodule

`default_nettype wire

// ==== tb_sha_accel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sha_accel_params.svh"

module tb_sha_accel;
  import sha_accel_pkg::*;

  localparam int MAX_BLOCKS  = 32;    // blocks hashed over the whole run, rounded up
  localparam int BUS_OPS     = 1500;  // bus requests, polling included
  localparam int CYCLE_LIMIT = 3 * (MAX_BLOCKS * (16 + 65) + 2 * BUS_OPS + 16);
  localparam int FLOOD_MAX   = 600;   // pushes before the fifo has to refuse one

  localparam hash_t SHA_IV = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  localparam word_t ROUND_K [64] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
    32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
    32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
    32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
    32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
    32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  logic        bus_clk;
  logic        bus_rstn;
  bus_addr_t   sys_addr;
  word_t       sys_wdata;
  logic        sys_wen;
  logic        sys_ren;
  word_t       sys_rdata;
  logic        sys_ack;
  logic        sys_err;
  logic        x11_activated;
  logic [31:0] lfsr_q;      // galois lfsr state
  word_t       msg_q [$];   // words the engine has accepted since its last reset
  int          cycles;

  sha_accel_top uut (
    .bus_clk         (bus_clk),
    .bus_rstn        (bus_rstn),
    .sys_addr_i      (sys_addr),
    .sys_wdata_i     (sys_wdata),
    .sys_wen_i       (sys_wen),
    .sys_ren_i       (sys_ren),
    .sys_rdata_o     (sys_rdata),
    .sys_ack_o       (sys_ack),
    .sys_err_o       (sys_err),
    .x11_activated_o (x11_activated)
  );

  initial begin
    bus_clk = 1'b0;
    forever #10 bus_clk = ~bus_clk;   // 20 ns period
  end

  always @(posedge bus_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      stop_with_failure($sformatf("timeout, the run did not end within %0d cycles", CYCLE_LIMIT));
    end
  end

  // ----------------------------------------------------------------------
  // random source and reference model

  function automatic word_t lfsr_bits(input int n);
    word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};                // one step per bit taken
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic word_t rotate_right(input word_t x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  // one compression of msg_q[base +: 16] onto h_in
  function automatic hash_t ref_block(input hash_t h_in, input int base);
    word_t w [64];
    word_t v [8];                                   // a .. h
    word_t s0;
    word_t s1;
    word_t ch;
    word_t mj;
    word_t t1;
    word_t t2;
    hash_t h_out;
    for (int t = 0; t < 16; t++) w[t] = msg_q[base + t];
    for (int t = 16; t < 64; t++) begin
      s0   = rotate_right(w[t-15], 7) ^ rotate_right(w[t-15], 18) ^ (w[t-15] >> 3);
      s1   = rotate_right(w[t-2], 17) ^ rotate_right(w[t-2], 19) ^ (w[t-2] >> 10);
      w[t] = w[t-16] + s0 + w[t-7] + s1;
    end
    for (int i = 0; i < 8; i++) v[i] = h_in[(7-i)*32 +: 32];
    for (int t = 0; t < 64; t++) begin
      s1 = rotate_right(v[4], 6) ^ rotate_right(v[4], 11) ^ rotate_right(v[4], 25);
      ch = (v[4] & v[5]) ^ (~v[4] & v[6]);
      t1 = v[7] + s1 + ch + ROUND_K[t] + w[t];
      s0 = rotate_right(v[0], 2) ^ rotate_right(v[0], 13) ^ rotate_right(v[0], 22);
      mj = (v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]);
      t2 = s0 + mj;
      for (int j = 7; j > 0; j--) v[j] = v[j-1];
      v[4] = v[4] + t1;                             // e = d + t1
      v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++) h_out[(7-i)*32 +: 32] = h_in[(7-i)*32 +: 32] + v[i];
    return h_out;
  endfunction

  // digest over every complete block in msg_q
  function automatic hash_t chained_digest();
    hash_t h;
    h = SHA_IV;
    for (int b = 0; b < msg_q.size() / 16; b++) h = ref_block(h, 16 * b);
    return h;
  endfunction

  // ----------------------------------------------------------------------
  // failure and compare tasks

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("error %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_hash(input hash_t got, input hash_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("error %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_cnt(input fifo_cnt_t got, input fifo_cnt_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("error %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  // ----------------------------------------------------------------------
  // bus tasks, called on a falling edge and back on the next one

  task automatic bus_access(input logic wr, input bus_addr_t addr, input word_t wdata,
                            output word_t rdata, output logic err);
    sys_addr  = addr;
    sys_wdata = wdata;
    sys_wen   = wr;
    sys_ren   = ~wr;
    @(negedge bus_clk);
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    if (sys_ack !== 1'b1) begin
      stop_with_failure($sformatf("bus request to %h got no ack one cycle later", addr));
    end
    rdata = sys_rdata;                              // registered, stable mid-cycle
    err   = sys_err;
  endtask

  task automatic bus_write(input bus_addr_t addr, input word_t data);
    word_t d;
    logic  e;
    bus_access(1'b1, addr, data, d, e);
    check_word(word_t'(e), '0, "error flag on a register write");
  endtask

  task automatic bus_read(input bus_addr_t addr, output word_t data);
    logic e;
    bus_access(1'b0, addr, '0, data, e);
    check_word(word_t'(e), '0, "error flag on a read");
  endtask

  task automatic push_word(input word_t data, output logic err);
    word_t d;
    bus_access(1'b1, `REG_SHA_PUSH, data, d, err);
  endtask

  // push that must be taken, recorded for the model
  task automatic push_ok(input word_t data);
    logic e;
    push_word(data, e);
    check_word(word_t'(e), '0, "error flag on a push");
    msg_q.push_back(data);
  endtask

  task automatic read_hash(output hash_t got);
    word_t d;
    for (int i = 0; i < 8; i++) begin
      bus_read(bus_addr_t'(`REG_SHA_HASH_BASE + 4 * i), d);   // H7 first
      got[i*32 +: 32] = d;
    end
  endtask

  // hash valid with an empty fifo belongs to the last block pushed
  task automatic wait_hash();
    word_t s;
    s = '0;
    while (!(s[1] && s[4])) begin
      bus_read(`REG_SHA_STATUS, s);
    end
  endtask

  task automatic engine_one_shot();
    word_t d;
    word_t exp;
    bus_write(`REG_SHA_CTRL, word_t'((1 << `SHA_CTRL_ENABLE) | (1 << `SHA_CTRL_RESET)));
    exp                   = '0;
    exp[`SHA_CTRL_ENABLE] = 1'b1;
    bus_read(`REG_SHA_CTRL, d);                     // reset bit still held in the register
    check_word(d, exp, "sha ctrl during the one-shot");
    msg_q.delete();
  endtask

  // ----------------------------------------------------------------------
  // test sequence

  initial begin
    word_t d;
    word_t c;
    word_t v;
    word_t exp;
    hash_t h;
    logic  e;
    int    n;
    int    nwords;

    lfsr_q    = 32'h658a;
    cycles    = 0;
    bus_rstn  = 1'b0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    repeat (16) @(posedge bus_clk);
    @(negedge bus_clk);
    bus_rstn = 1'b1;

    // reset values
    bus_read(`REG_VERSION, d);
    check_word(d, `BUILD_DATE, "version word");
    bus_read(`REG_CTRL, d);
    check_word(d, '0, "ctrl after reset");
    bus_read(`REG_STATUS, d);
    check_word(d, '0, "status after reset");
    bus_read(`REG_SHA_CTRL, d);
    check_word(d, '0, "sha ctrl after reset");
    exp    = '0;
    exp[0] = 1'b1;                                  // ready, engine idle
    exp[4] = 1'b1;                                  // fifo empty
    bus_read(`REG_SHA_STATUS, d);
    check_word(d, exp, "sha status after reset");
    bus_read(`REG_SHA_FIFO_CNT, d);
    check_cnt(fifo_cnt_t'(d), '0, "fifo count after reset");
    read_hash(h);
    check_hash(h, '0, "hash words after reset");
    bus_read(20'h00008, d);
    check_word(d, '0, "unmapped 0x008");
    bus_read(20'h00200, d);
    check_word(d, '0, "unmapped 0x200");
    bus_read(`REG_SHA_PUSH, d);
    check_word(d, '0, "write-only push port");

    // control readback with random values
    for (int i = 0; i < 6; i++) begin
      c = lfsr_bits(32);
      v = lfsr_bits(32);
      bus_write(`REG_CTRL, c);
      bus_write(`REG_SHA_CTRL, v);
      check_word(word_t'(x11_activated), word_t'(c[`CTRL_ENABLE]), "x11_activated_o");
      bus_read(`REG_CTRL, d);
      check_word(d, c, "ctrl readback");
      bus_read(`REG_SHA_CTRL, d);
      exp                  = v;
      exp[`SHA_CTRL_RESET] = 1'b0;                  // one-shot reads as 0
      check_word(d, exp, "sha ctrl readback");
      exp    = '0;
      exp[0] = c[`CTRL_ENABLE];
      exp[4] = c[`CTRL_ENABLE] & v[`SHA_CTRL_ENABLE];   // engine out of soft reset
      bus_read(`REG_STATUS, d);
      check_word(d, exp, "status after ctrl writes");
    end

    // one padded block, message of nwords random words
    bus_write(`REG_CTRL, word_t'(1 << `CTRL_ENABLE));
    engine_one_shot();
    nwords = int'(lfsr_bits(4)) % 14;
    for (int i = 0; i < nwords; i++) push_ok(lfsr_bits(32));
    push_ok(32'h8000_0000);                         // end marker
    for (int i = nwords + 1; i < 15; i++) push_ok('0);
    push_ok(word_t'(nwords * 32));                  // bit length, upper word stays 0
    wait_hash();
    read_hash(h);
    check_hash(h, chained_digest(), "single block digest");

    // two or three blocks back to back
    engine_one_shot();
    n = 2 + int'(lfsr_bits(1));
    for (int i = 0; i < 16 * n; i++) push_ok(lfsr_bits(32));
    wait_hash();
    read_hash(h);
    check_hash(h, chained_digest(), "chained digest");
    bus_read(`REG_SHA_FIFO_CNT, d);
    check_cnt(fifo_cnt_t'(d), '0, "fifo count after chain");

    // global enable off holds the fifo in reset, the push is lost
    bus_write(`REG_CTRL, '0);
    push_word(lfsr_bits(32), e);
    check_word(word_t'(e), '0, "push with enable off");
    bus_read(`REG_SHA_FIFO_CNT, d);
    check_cnt(fifo_cnt_t'(d), '0, "fifo count, enable off");
    bus_write(`REG_CTRL, word_t'(1 << `CTRL_ENABLE));
    engine_one_shot();

    // flood until the fifo refuses a word
    e = 1'b0;
    n = 0;
    while (!e) begin
      if (n >= FLOOD_MAX) begin
        stop_with_failure("the fifo never filled up, no push was refused with an error");
      end
      v = lfsr_bits(32);
      push_word(v, e);
      n++;
      if (!e) msg_q.push_back(v);                   // refused words never reach the engine
    end
    d = '1;
    while (d != '0) bus_read(`REG_SHA_FIFO_CNT, d);
    repeat ((16 - msg_q.size() % 16) % 16) push_ok(lfsr_bits(32));   // close the open block
    wait_hash();
    read_hash(h);
    check_hash(h, chained_digest(), "digest after overflow");

    // one-shot with words still queued
    for (int i = 0; i < 40; i++) push_ok(lfsr_bits(32));
    engine_one_shot();
    bus_read(`REG_SHA_FIFO_CNT, d);
    check_cnt(fifo_cnt_t'(d), '0, "fifo count after one-shot");
    read_hash(h);
    check_hash(h, '0, "hash words after one-shot");

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sha_accel_top.f ====
+incdir+.
sha_accel_pkg.sv
sha_bus_regs.sv
sha_word_fifo.sv
sha256_compress.sv
sha_accel_top.sv
tb_sha_accel.sv

// ==== Bender.yml ====
package:
  name: sha_accel

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - sha_accel_pkg.sv
      - sha_bus_regs.sv
      - sha_word_fifo.sv
      - sha256_compress.sv
      - sha_accel_top.sv
      - target: test
        files:
          - tb_sha_accel.sv
